//--- Makefile
# Verilator flow for the SD command path

VERILATOR  ?= verilator
TOP        ?= tb_sd_cmd
RTL_TOP    ?= sd_cmd_top
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= Finished with no errors
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/sd_cmd_pkg.sv
// SD command path package with state, error and response-kind encodings and timing constants
package sd_cmd_pkg;

    // SD clock half period in i_clk cycles, must be 2 or more
    localparam int CLK_DIV = 4;
    localparam int DIV_W = $clog2(CLK_DIV);

    // SD clock rising edges allowed before the response start bit
    localparam int RESP_TIMEOUT = 64;
    localparam int TMO_W = $clog2(RESP_TIMEOUT);

    // Command FSM states
    // Transmit states come first, receive states start at ST_RESP_WAIT
    localparam logic [3:0] ST_IDLE          = 4'd0;
    localparam logic [3:0] ST_REQ_CONTENT   = 4'd1;
    localparam logic [3:0] ST_REQ_CRC7      = 4'd2;
    localparam logic [3:0] ST_REQ_STOPBIT   = 4'd3;
    localparam logic [3:0] ST_RESP_WAIT     = 4'd4;
    localparam logic [3:0] ST_RESP_TRANSBIT = 4'd5;
    localparam logic [3:0] ST_RESP_MIRROR   = 4'd6;
    localparam logic [3:0] ST_RESP_REG      = 4'd7;
    localparam logic [3:0] ST_RESP_CRC7     = 4'd8;
    localparam logic [3:0] ST_RESP_STOPBIT  = 4'd9;

    // Error codes reported with each response and held in the error latch
    localparam logic [2:0] ERR_NONE         = 3'd0;
    localparam logic [2:0] ERR_NO_RESPONSE  = 3'd1;
    localparam logic [2:0] ERR_BAD_TRANSBIT = 3'd2;
    localparam logic [2:0] ERR_BAD_STOPBIT  = 3'd3;
    localparam logic [2:0] ERR_BAD_CRC      = 3'd4;

    // Response kinds
    // R3 carries the OCR and an all-ones CRC field, so its CRC is not checked
    localparam logic [1:0] RESP_R1 = 2'd0;
    localparam logic [1:0] RESP_R3 = 2'd1;
    localparam logic [1:0] RESP_R6 = 2'd2;

endpackage

//--- files.f
common/sd_cmd_pkg.sv
logic/sd_clkgen.sv
logic/sd_crc7.sv
sd_cmd/sd_cmd_fsm.sv
logic/sd_cmd_top.sv
tests/sd_card_model.sv
tests/tb_sd_cmd.sv

//--- logic/sd_clkgen.sv
// SD clock generator dividing i_clk and giving one-cycle strobes ahead of each SD clock edge
`timescale 1ns/1ps

module sd_clkgen import sd_cmd_pkg::*; (
    input  logic i_clk,
    input  logic i_nrst,
    output logic o_sd_clk,
    output logic o_sclk_rise,
    output logic o_sclk_fall
);

    logic [DIV_W-1:0] div_cnt;
    logic             sclk;
    logic             edge_next;

    // Last cycle of a half period, the SD clock toggles on the next i_clk edge
    assign edge_next = (div_cnt == DIV_W'(CLK_DIV - 1));

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            div_cnt <= '0;
            sclk    <= 1'b0;
        end else if (edge_next) begin
            div_cnt <= '0;
            sclk    <= ~sclk;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Strobes lead the edge by one cycle so FSM registers update with the edge
    assign o_sclk_rise = edge_next & ~sclk;
    assign o_sclk_fall = edge_next & sclk;
    assign o_sd_clk    = sclk;

endmodule

//--- logic/sd_cmd_top.sv
// SD host command path top, joining clock generator, CRC7 unit and command FSM
`timescale 1ns/1ps

module sd_cmd_top import sd_cmd_pkg::*; (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_req_valid,
    input  logic [5:0]  i_req_cmd,
    input  logic [31:0] i_req_arg,
    input  logic [1:0]  i_req_kind,
    output logic        o_req_ready,
    output logic        o_resp_valid,
    output logic [5:0]  o_resp_cmd,
    output logic [31:0] o_resp_reg,
    output logic [2:0]  o_resp_err,
    input  logic        i_resp_ready,
    input  logic        i_clear_err,
    input  logic        i_sd_cmd,
    output logic        o_sd_clk,
    output logic        o_sd_cmd,
    output logic        o_sd_cmd_oe,
    output logic [2:0]  o_cmd_err
);

    logic       sclk_rise;
    logic       sclk_fall;
    logic       crc_clear;
    logic       crc_shift;
    logic       crc_bit;
    logic [6:0] crc;

    sd_clkgen sd_clkgen_inst (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .o_sd_clk    (o_sd_clk),
        .o_sclk_rise (sclk_rise),
        .o_sclk_fall (sclk_fall)
    );

    sd_crc7 sd_crc7_inst (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (crc_clear),
        .i_shift (crc_shift),
        .i_bit   (crc_bit),
        .o_crc   (crc)
    );

    sd_cmd_fsm sd_cmd_fsm_inst (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_sclk_rise  (sclk_rise),
        .i_sclk_fall  (sclk_fall),
        .i_sd_cmd     (i_sd_cmd),
        .i_req_valid  (i_req_valid),
        .i_req_cmd    (i_req_cmd),
        .i_req_arg    (i_req_arg),
        .i_req_kind   (i_req_kind),
        .i_resp_ready (i_resp_ready),
        .i_clear_err  (i_clear_err),
        .i_crc        (crc),
        .o_sd_cmd     (o_sd_cmd),
        .o_sd_cmd_oe  (o_sd_cmd_oe),
        .o_req_ready  (o_req_ready),
        .o_crc_clear  (crc_clear),
        .o_crc_shift  (crc_shift),
        .o_crc_bit    (crc_bit),
        .o_resp_valid (o_resp_valid),
        .o_resp_cmd   (o_resp_cmd),
        .o_resp_reg   (o_resp_reg),
        .o_resp_err   (o_resp_err),
        .o_cmd_err    (o_cmd_err)
    );

endmodule

//--- logic/sd_crc7.sv
// CRC7 unit for SD command frames, serial input with clear and shift enable
`timescale 1ns/1ps

module sd_crc7 import sd_cmd_pkg::*; (
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_clear,
    input  logic       i_shift,
    input  logic       i_bit,
    output logic [6:0] o_crc
);

    logic [6:0] crc;
    logic       fb;

    // Polynomial x^7 + x^3 + 1, MSB first
    assign fb = i_bit ^ crc[6];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            crc <= '0;
        end else if (i_clear) begin
            crc <= '0;
        end else if (i_shift) begin
            crc <= {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
        end
    end

    assign o_crc = crc;

    // The FSM never clears and shifts in the same cycle
    a_clear_shift: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(i_clear && i_shift))
        else $error("CRC7 clear and shift asserted together");

endmodule

//--- sd_cmd/sd_cmd_fsm.sv
// SD command FSM sending request frames and receiving and checking R1, R3 and R6 responses
`timescale 1ns/1ps

module sd_cmd_fsm import sd_cmd_pkg::*; (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_sclk_rise,
    input  logic        i_sclk_fall,
    input  logic        i_sd_cmd,
    input  logic        i_req_valid,
    input  logic [5:0]  i_req_cmd,
    input  logic [31:0] i_req_arg,
    input  logic [1:0]  i_req_kind,
    input  logic        i_resp_ready,
    input  logic        i_clear_err,
    input  logic [6:0]  i_crc,
    output logic        o_sd_cmd,
    output logic        o_sd_cmd_oe,
    output logic        o_req_ready,
    output logic        o_crc_clear,
    output logic        o_crc_shift,
    output logic        o_crc_bit,
    output logic        o_resp_valid,
    output logic [5:0]  o_resp_cmd,
    output logic [31:0] o_resp_reg,
    output logic [2:0]  o_resp_err,
    output logic [2:0]  o_cmd_err
);

    logic [3:0]       state;
    logic [39:0]      tx_shift;
    logic [5:0]       bit_cnt;
    logic [TMO_W-1:0] tmo_cnt;
    logic             resp_valid;
    logic [2:0]       resp_err;
    logic [2:0]       cmd_err;
    logic             cmd_oe;

    // Response payload
    logic [1:0]       kind;
    logic [5:0]       mirror;
    logic [31:0]      reg_word;
    logic [6:0]       crc_rx;
    logic [6:0]       crc_calc;

    logic             req_fire;
    logic             done;
    logic [2:0]       done_err;

    // Requests are taken on a fall strobe when nothing is pending
    assign o_req_ready = i_sclk_fall && (state == ST_IDLE) && (cmd_err == ERR_NONE)
                         && !resp_valid;
    assign req_fire = o_req_ready && i_req_valid;

    // End of a receive with or without an error
    always_comb begin
        done     = 1'b0;
        done_err = ERR_NONE;
        if (i_sclk_rise) begin
            case (state)
                ST_RESP_WAIT: begin
                    if (i_sd_cmd && (tmo_cnt == '0)) begin
                        done     = 1'b1;
                        done_err = ERR_NO_RESPONSE;
                    end
                end
                ST_RESP_TRANSBIT: begin
                    if (i_sd_cmd) begin
                        done     = 1'b1;
                        done_err = ERR_BAD_TRANSBIT;
                    end
                end
                ST_RESP_STOPBIT: begin
                    done = 1'b1;
                    if (!i_sd_cmd) begin
                        done_err = ERR_BAD_STOPBIT;
                    end else if ((kind != RESP_R3) && (crc_rx != crc_calc)) begin
                        done_err = ERR_BAD_CRC;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state      <= ST_IDLE;
            tx_shift   <= '1;
            bit_cnt    <= '0;
            tmo_cnt    <= '0;
            resp_valid <= 1'b0;
            resp_err   <= ERR_NONE;
            cmd_err    <= ERR_NONE;
            cmd_oe     <= 1'b0;
        end else begin
            if (resp_valid && i_resp_ready) begin
                resp_valid <= 1'b0;
            end
            if (i_clear_err) begin
                cmd_err <= ERR_NONE;
            end

            if (i_sclk_fall) begin
                // Transmit side changes the CMD line after fall strobes
                case (state)
                    ST_IDLE: begin
                        if (req_fire) begin
                            tx_shift <= {2'b01, i_req_cmd, i_req_arg};
                            bit_cnt  <= 6'd39;
                            cmd_oe   <= 1'b1;
                            state    <= ST_REQ_CONTENT;
                        end
                    end
                    ST_REQ_CONTENT: begin
                        if (bit_cnt != '0) begin
                            tx_shift <= {tx_shift[38:0], 1'b1};
                            bit_cnt  <= bit_cnt - 6'd1;
                        end else begin
                            // CRC bits next and the end bit from the ones below them
                            tx_shift <= {i_crc, 1'b1, 32'hffff_ffff};
                            bit_cnt  <= 6'd6;
                            state    <= ST_REQ_CRC7;
                        end
                    end
                    ST_REQ_CRC7: begin
                        tx_shift <= {tx_shift[38:0], 1'b1};
                        if (bit_cnt != '0) begin
                            bit_cnt <= bit_cnt - 6'd1;
                        end else begin
                            state <= ST_REQ_STOPBIT;
                        end
                    end
                    ST_REQ_STOPBIT: begin
                        // Line turns around after the end bit
                        cmd_oe  <= 1'b0;
                        tmo_cnt <= TMO_W'(RESP_TIMEOUT - 1);
                        state   <= ST_RESP_WAIT;
                    end
                    default: ;
                endcase
            end else if (i_sclk_rise) begin
                // Receive side samples the CMD line on rise strobes
                case (state)
                    ST_RESP_WAIT: begin
                        if (!i_sd_cmd) begin
                            state <= ST_RESP_TRANSBIT;
                        end else if (tmo_cnt != '0) begin
                            tmo_cnt <= tmo_cnt - 1'b1;
                        end
                    end
                    ST_RESP_TRANSBIT: begin
                        bit_cnt <= 6'd5;
                        if (!i_sd_cmd) begin
                            state <= ST_RESP_MIRROR;
                        end
                    end
                    ST_RESP_MIRROR: begin
                        if (bit_cnt != '0) begin
                            bit_cnt <= bit_cnt - 6'd1;
                        end else begin
                            bit_cnt <= 6'd31;
                            state   <= ST_RESP_REG;
                        end
                    end
                    ST_RESP_REG: begin
                        if (bit_cnt != '0) begin
                            bit_cnt <= bit_cnt - 6'd1;
                        end else begin
                            bit_cnt <= 6'd6;
                            state   <= ST_RESP_CRC7;
                        end
                    end
                    ST_RESP_CRC7: begin
                        if (bit_cnt != '0) begin
                            bit_cnt <= bit_cnt - 6'd1;
                        end else begin
                            state <= ST_RESP_STOPBIT;
                        end
                    end
                    default: ;
                endcase

                if (done) begin
                    state      <= ST_IDLE;
                    resp_valid <= 1'b1;
                    resp_err   <= done_err;
                    if (done_err != ERR_NONE) begin
                        cmd_err <= done_err;
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (req_fire) begin
            kind <= i_req_kind;
        end
        if (i_sclk_rise) begin
            case (state)
                ST_RESP_MIRROR: mirror <= {mirror[4:0], i_sd_cmd};
                ST_RESP_REG:    reg_word <= {reg_word[30:0], i_sd_cmd};
                ST_RESP_CRC7: begin
                    crc_rx <= {crc_rx[5:0], i_sd_cmd};
                    // Last register bit went in one SD period ago
                    if (bit_cnt == 6'd6) begin
                        crc_calc <= i_crc;
                    end
                end
                default: ;
            endcase
        end
    end

    // CRC unit control
    assign o_crc_clear = (state == ST_IDLE) || (state == ST_REQ_CRC7);
    assign o_crc_bit   = (state == ST_REQ_CONTENT) ? tx_shift[39] : i_sd_cmd;

    always_comb begin
        case (state)
            ST_REQ_CONTENT:   o_crc_shift = i_sclk_rise;
            ST_RESP_WAIT:     o_crc_shift = i_sclk_rise && !i_sd_cmd;
            ST_RESP_TRANSBIT,
            ST_RESP_MIRROR,
            ST_RESP_REG:      o_crc_shift = i_sclk_rise;
            default:          o_crc_shift = 1'b0;
        endcase
    end

    assign o_sd_cmd    = tx_shift[39];
    assign o_sd_cmd_oe = cmd_oe;

    assign o_resp_valid = resp_valid;
    assign o_resp_cmd   = mirror;
    assign o_resp_reg   = reg_word;
    assign o_resp_err   = resp_err;
    assign o_cmd_err    = cmd_err;

    // A pending response holds until the host takes it
    a_resp_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (o_resp_valid && !i_resp_ready) |=>
            (o_resp_valid && $stable({o_resp_cmd, o_resp_reg, o_resp_err})))
        else $error("Response dropped or changed before transfer");

    a_rx_no_drive: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (state >= ST_RESP_WAIT) |-> !o_sd_cmd_oe)
        else $error("CMD line driven while receiving");

endmodule

//--- tests/sd_card_model.sv
// Behavioral SD card that captures command frames and answers with a response frame
`timescale 1ns/1ps

module sd_card_model (
    input  logic        i_sd_clk,
    input  logic        i_sd_cmd,
    input  logic        i_sd_cmd_oe,
    input  logic [47:0] i_resp_frame,
    input  logic [7:0]  i_gap,
    input  logic        i_silent,
    input  logic        i_bad_crc,
    output logic        o_sd_cmd,
    output logic [47:0] o_cmd_frame,
    output logic [15:0] o_frame_cnt
);

    logic [47:0] rx_shift;
    int          rx_bits;

    // One response bit per falling SD clock edge, start bit after i_gap idle edges
    task automatic send_response();
        logic [47:0] frame;
        int          i;
        frame = i_resp_frame;
        // Flip the CRC LSB
        if (i_bad_crc) begin
            frame[1] = ~frame[1];
        end
        repeat (i_gap) @(negedge i_sd_clk);
        for (i = 47; i >= 0; i--) begin
            @(negedge i_sd_clk);
            #1;
            o_sd_cmd = frame[i];
        end
        @(negedge i_sd_clk);
        #1;
        o_sd_cmd = 1'b1;
    endtask

    initial begin : card_loop
        o_sd_cmd    = 1'b1;
        o_cmd_frame = '0;
        o_frame_cnt = '0;
        rx_shift    = '0;
        rx_bits     = 0;
        forever begin
            @(posedge i_sd_clk);
            // Host drives the line only while its output enable is high
            if (i_sd_cmd_oe) begin
                rx_shift = {rx_shift[46:0], i_sd_cmd};
                rx_bits++;
                if (rx_bits == 48) begin
                    o_cmd_frame = rx_shift;
                    o_frame_cnt = o_frame_cnt + 16'd1;
                    rx_bits     = 0;
                    if (!i_silent) begin
                        send_response();
                    end
                end
            end
        end
    end

endmodule

//--- tests/tb_sd_cmd.sv
// Testbench for the SD command path with a card model and reference frame and CRC7 models
`timescale 1ns/1ps

module tb_sd_cmd import sd_cmd_pkg::*; ();

    localparam int SCLK_CYCLES = 2 * CLK_DIV;
    localparam int REQ_WAIT    = 8 * SCLK_CYCLES;
    localparam int RESP_WAIT   = (2 * 48 + RESP_TIMEOUT + 32) * SCLK_CYCLES * 4;

    logic        clk;
    logic        nrst;
    logic        req_valid;
    logic [5:0]  req_cmd;
    logic [31:0] req_arg;
    logic [1:0]  req_kind;
    logic        req_ready;
    logic        resp_valid;
    logic [5:0]  resp_cmd;
    logic [31:0] resp_reg;
    logic [2:0]  resp_err;
    logic        resp_ready;
    logic        clear_err;
    logic [2:0]  cmd_err;
    logic        sd_clk;
    logic        host_cmd;
    logic        host_cmd_oe;
    logic        card_cmd;
    logic [47:0] card_resp;
    logic [7:0]  card_gap;
    logic        card_silent;
    logic        card_bad_crc;
    logic [47:0] card_frame;
    logic [15:0] card_frame_cnt;

    // Expected response word is {check payload, error, index, register}
    logic [47:0] exp_frame_q[$];
    logic [41:0] exp_resp_q[$];
    int          cmd_count;
    int          resp_count;

    sd_cmd_top sd_cmd_top_inst (
        .i_clk        (clk),
        .i_nrst       (nrst),
        .i_req_valid  (req_valid),
        .i_req_cmd    (req_cmd),
        .i_req_arg    (req_arg),
        .i_req_kind   (req_kind),
        .o_req_ready  (req_ready),
        .o_resp_valid (resp_valid),
        .o_resp_cmd   (resp_cmd),
        .o_resp_reg   (resp_reg),
        .o_resp_err   (resp_err),
        .i_resp_ready (resp_ready),
        .i_clear_err  (clear_err),
        .i_sd_cmd     (card_cmd),
        .o_sd_clk     (sd_clk),
        .o_sd_cmd     (host_cmd),
        .o_sd_cmd_oe  (host_cmd_oe),
        .o_cmd_err    (cmd_err)
    );

    sd_card_model sd_card_model_inst (
        .i_sd_clk     (sd_clk),
        .i_sd_cmd     (host_cmd),
        .i_sd_cmd_oe  (host_cmd_oe),
        .i_resp_frame (card_resp),
        .i_gap        (card_gap),
        .i_silent     (card_silent),
        .i_bad_crc    (card_bad_crc),
        .o_sd_cmd     (card_cmd),
        .o_cmd_frame  (card_frame),
        .o_frame_cnt  (card_frame_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_run($sformatf("Mismatch at %0t: %s, got %0h, expected %0h",
                               $time, what, actual, expected));
        end
    endtask

    // CRC7 with polynomial x^7 + x^3 + 1 over 40 bits and MSB first
    function automatic logic [6:0] crc7_ref(input logic [39:0] data);
        logic [6:0] crc;
        logic       fb;
        int         i;
        crc = '0;
        for (i = 39; i >= 0; i--) begin
            fb  = data[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    function automatic logic [47:0] build_frame(input logic trans, input logic [5:0] idx,
                                                input logic [31:0] payload);
        logic [39:0] head;
        head = {1'b0, trans, idx, payload};
        return {head, crc7_ref(head), 1'b1};
    endfunction

    // R3 has reserved ones in place of the index and the CRC
    function automatic logic [47:0] response_frame(input logic [5:0] idx, input logic [1:0] kind,
                                                   input logic [31:0] reg_val);
        if (kind == RESP_R3) begin
            return {2'b00, 6'h3f, reg_val, 7'h7f, 1'b1};
        end
        return build_frame(1'b0, idx, reg_val);
    endfunction

    function automatic logic [41:0] expected_response(input logic [5:0] idx,
            input logic [1:0] kind, input logic [31:0] reg_val, input logic silent,
            input logic bad_crc);
        logic [2:0] err;
        logic [5:0] mirror;
        mirror = (kind == RESP_R3) ? 6'h3f : idx;
        if (silent) begin
            err = ERR_NO_RESPONSE;
        end else if (bad_crc && (kind != RESP_R3)) begin
            err = ERR_BAD_CRC;
        end else begin
            err = ERR_NONE;
        end
        return {!silent, err, mirror, reg_val};
    endfunction

    // Returns once a response is pending, or once all of them have transferred
    task automatic wait_response(input logic all_done);
        int   waited;
        logic done;
        waited = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = (resp_count >= cmd_count) || (!all_done && resp_valid);
            waited++;
            if (!done && (waited > RESP_WAIT)) begin
                stop_run($sformatf("Error at %0t: no response arrived in time", $time));
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic send_command(input logic [5:0] idx, input logic [31:0] arg,
                                input logic [1:0] kind, input logic [31:0] reg_val,
                                input logic [7:0] gap, input logic silent,
                                input logic bad_crc);
        int   waited;
        logic accepted;
        exp_frame_q.push_back(build_frame(1'b1, idx, arg));
        exp_resp_q.push_back(expected_response(idx, kind, reg_val, silent, bad_crc));
        card_resp    = response_frame(idx, kind, reg_val);
        card_gap     = gap;
        card_silent  = silent;
        card_bad_crc = bad_crc;
        req_valid    = 1'b1;
        req_cmd      = idx;
        req_arg      = arg;
        req_kind     = kind;
        waited       = 0;
        accepted     = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = req_ready;
            waited++;
            if (!accepted && (waited > REQ_WAIT)) begin
                stop_run($sformatf("Error at %0t: request was not accepted in time", $time));
            end
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        cmd_count++;
        wait_response(1'b0);
    endtask

    // Error latch must block requests until it is cleared
    task automatic hold_error(input logic [2:0] err);
        int i;
        for (i = 0; i < 6 * SCLK_CYCLES; i++) begin
            @(negedge clk);
            check_value(64'(cmd_err), 64'(err), "latched error");
            check_value(64'(req_ready), 64'd0, "request ready while an error is latched");
        end
        @(posedge clk);
        #1;
        clear_err = 1'b1;
        @(posedge clk);
        #1;
        clear_err = 1'b0;
    endtask

    initial begin : ready_stalls
        forever begin
            @(posedge clk);
            #1;
            resp_ready = ($urandom % 3 != 0);
        end
    end

    // SD clock toggles every CLK_DIV cycles once out of reset
    initial begin : sclk_monitor
        int   cycles;
        logic last;
        logic seen;
        cycles = 0;
        last   = 1'b0;
        seen   = 1'b0;
        forever begin
            @(negedge clk);
            cycles++;
            if (!nrst) begin
                cycles = 0;
                seen   = 1'b0;
                last   = sd_clk;
            end else if (sd_clk !== last) begin
                if (seen) begin
                    check_value(64'(cycles), 64'(CLK_DIV), "SD clock half period");
                end
                seen   = 1'b1;
                last   = sd_clk;
                cycles = 0;
            end
        end
    end

    initial begin : compare
        logic [40:0] held;
        logic        holding;
        logic [41:0] exp;
        logic [15:0] frames_seen;
        holding     = 1'b0;
        frames_seen = '0;
        forever begin
            @(negedge clk);
            if (card_frame_cnt != frames_seen) begin
                if (exp_frame_q.size() == 0) begin
                    stop_run($sformatf("Error at %0t: card saw a frame nobody sent", $time));
                end
                check_value(64'(card_frame), 64'(exp_frame_q.pop_front()), "command frame");
                frames_seen = frames_seen + 16'd1;
            end
            if (resp_valid) begin
                check_value(64'(req_ready), 64'd0, "request ready while a response is pending");
                if (holding) begin
                    check_value(64'({resp_cmd, resp_reg, resp_err}), 64'(held),
                                "response payload during a stall");
                end
                held    = {resp_cmd, resp_reg, resp_err};
                holding = 1'b1;
                if (resp_ready) begin
                    if (exp_resp_q.size() == 0) begin
                        stop_run($sformatf("Error at %0t: response with no command", $time));
                    end
                    exp = exp_resp_q.pop_front();
                    check_value(64'(resp_err), 64'(exp[40:38]), "response error");
                    if (exp[41]) begin
                        check_value(64'(resp_cmd), 64'(exp[37:32]), "response index");
                        check_value(64'(resp_reg), 64'(exp[31:0]), "response register");
                    end
                    resp_count++;
                    holding = 1'b0;
                end
            end
        end
    end

    initial begin : stimulus
        int         i;
        logic [1:0] kind;
        nrst         = 1'b0;
        req_valid    = 1'b0;
        req_cmd      = '0;
        req_arg      = '0;
        req_kind     = RESP_R1;
        resp_ready   = 1'b0;
        clear_err    = 1'b0;
        card_resp    = '1;
        card_gap     = '0;
        card_silent  = 1'b0;
        card_bad_crc = 1'b0;
        cmd_count    = 0;
        resp_count   = 0;
        void'($urandom(32'ha5fe));

        // Known CRC7 of CMD0 with a zero argument
        check_value(64'(crc7_ref(40'h40_0000_0000)), 64'h4a, "reference CRC7 of CMD0");

        repeat (7) @(posedge clk);
        @(negedge clk);
        check_value(64'(req_ready), 64'd0, "request ready in reset");
        check_value(64'(resp_valid), 64'd0, "response valid in reset");
        check_value(64'(host_cmd_oe), 64'd0, "CMD output enable in reset");
        check_value(64'(host_cmd), 64'd1, "CMD line in reset");
        check_value(64'(cmd_err), 64'(ERR_NONE), "error in reset");
        @(posedge clk);
        #1;
        nrst = 1'b1;

        for (i = 0; i < 12; i++) begin
            kind = ($urandom % 2 == 0) ? RESP_R1 : RESP_R6;
            send_command(6'($urandom), $urandom, kind, $urandom, 8'($urandom % 16),
                         1'b0, 1'b0);
        end
        for (i = 0; i < 3; i++) begin
            send_command(6'd41, $urandom, RESP_R3, $urandom, 8'($urandom % 16), 1'b0, 1'b0);
        end

        send_command(6'd8, $urandom, RESP_R1, $urandom, 8'd0, 1'b1, 1'b0);
        hold_error(ERR_NO_RESPONSE);
        send_command(6'd8, $urandom, RESP_R1, $urandom, 8'd2, 1'b0, 1'b0);

        send_command(6'd17, $urandom, RESP_R1, $urandom, 8'd3, 1'b0, 1'b1);
        hold_error(ERR_BAD_CRC);
        send_command(6'd13, $urandom, RESP_R1, $urandom, 8'd1, 1'b0, 1'b0);

        wait_response(1'b1);
        check_value(64'(resp_count), 64'(cmd_count), "number of responses");
        check_value(64'(exp_frame_q.size()), 64'd0, "frames still expected");
        $display("Finished with no errors");
        $finish;
    end

endmodule
